//--- src/llki_pkg.sv
// Shared widths, types and message encodings for the LLKI protocol processor, imported by every RTL module
`default_nettype none

package llki_pkg;

  // --------------------
  // Bus widths and word types
  // --------------------
  localparam int REG_DATA_W = 64;
  localparam int REG_ADDR_W = 32;

  typedef logic [REG_DATA_W-1:0] reg_data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // --------------------
  // Message IDs carried in header bits 7:0
  // --------------------
  typedef enum logic [7:0] {
    MID_LOAD_KEY_REQ    = 8'h04,
    MID_CLEAR_KEY_REQ   = 8'h05,
    MID_KEY_STATUS_REQ  = 8'h06,
    MID_LOAD_KEY_ACK    = 8'h07,
    MID_CLEAR_KEY_ACK   = 8'h08,
    MID_KEY_STATUS_RESP = 8'h09,
    MID_ERROR_RESP      = 8'h0A
  } llki_msg_id_e;

  // Status codes carried in header bits 15:8
  typedef enum logic [7:0] {
    ST_GOOD            = 8'h00,
    ST_KEY_PRESENT     = 8'h01,
    ST_KEY_NOT_PRESENT = 8'h02,
    // Error group starts at 0x20
    ST_BAD_MSG_ID      = 8'h20,
    ST_BAD_MSG_LEN     = 8'h21,
    ST_KEY_OVERWRITE   = 8'h22,
    ST_LOSS_OF_SYNC    = 8'h23,
    ST_BAD_KEY_LEN     = 8'h24
  } llki_status_e;

  // Protocol FSM states
  typedef enum logic [2:0] {
    IDLE,
    MSG_CHECK,
    LOAD_KEY_WORDS,
    WAIT_COMPLETE,
    CLEAR_KEY,
    RESPONSE
  } llki_state_e;

  // Control/status word bit positions
  localparam int CTRLSTS_RESP_WAITING  = 0;
  localparam int CTRLSTS_READY_FOR_KEY = 1;

endpackage

`default_nettype wire

//--- src/llki_reg_decode.sv
// Register decode stage: address checks, acknowledge/error timing, read mux and send/receive strobes
`timescale 1ns/10ps
`default_nettype none

module llki_reg_decode import llki_pkg::*; #(
  parameter reg_addr_t CTRLSTS_ADDR  = 32'h0000_0000,
  parameter reg_addr_t SENDRECV_ADDR = 32'h0000_0008
) (
  input  wire logic      clk,
  input  wire logic      rst,
  // Host strobe port
  input  wire logic      reg_we_i,
  input  wire logic      reg_re_i,
  input  wire reg_addr_t reg_addr_i,
  output reg_data_t      reg_rdata_o,
  output logic           reg_err_o,
  output logic           reg_ack_o,
  // Status inputs
  input  wire logic      key_ready_i,
  input  wire logic      resp_waiting_i,
  input  wire reg_data_t resp_word_i,
  // Qualified strobes towards the FSM
  output logic           sr_write_o,
  output logic           sr_read_o
);

  logic [1:0] ctrlsts;
  logic       hit_ctrlsts;
  logic       hit_sendrecv;
  logic       addr_valid;
  logic       wr_ack_q;
  logic       wr_err_q;

  // --------------------
  // Address decode
  // --------------------
  assign hit_ctrlsts  = (reg_addr_i == CTRLSTS_ADDR);
  assign hit_sendrecv = (reg_addr_i == SENDRECV_ADDR);
  assign addr_valid   = hit_ctrlsts || hit_sendrecv;

  // Send/receive accesses go straight on to the message stage
  assign sr_write_o = reg_we_i && hit_sendrecv;
  assign sr_read_o  = reg_re_i && hit_sendrecv;

  // --------------------
  // Registered state
  // --------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrlsts  <= '0;
      wr_ack_q <= 1'b0;
      wr_err_q <= 1'b0;
    end else begin
      // Status bits are a one-cycle sample of the live levels
      ctrlsts[CTRLSTS_RESP_WAITING]  <= resp_waiting_i;
      ctrlsts[CTRLSTS_READY_FOR_KEY] <= key_ready_i;
      // Writes are answered on the following cycle
      wr_ack_q <= reg_we_i;
      // Control/status has no writable bits, so only unmapped writes fail
      wr_err_q <= reg_we_i && !addr_valid;
    end
  end

  // Read data mux, valid alongside the read strobe
  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      if (hit_ctrlsts) begin
        reg_rdata_o[1:0] = ctrlsts;
      end else if (hit_sendrecv) begin
        reg_rdata_o = resp_word_i;
      end
    end
  end

  // Reads respond in the same cycle, writes one later
  assign reg_ack_o = reg_re_i || wr_ack_q;
  assign reg_err_o = (reg_re_i && !addr_valid) || wr_err_q;

endmodule

`default_nettype wire

//--- src/llki_msg_fsm.sv
// Message stage: LLKI protocol FSM that checks requests, drives the key port and builds responses
`timescale 1ns/10ps
`default_nettype none

module llki_msg_fsm import llki_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  // Qualified send/receive accesses
  input  wire logic      sr_write_i,
  input  wire logic      sr_read_i,
  input  wire reg_data_t wdata_i,
  // Key discrete port
  input  wire logic      key_ready_i,
  input  wire logic      key_complete_i,
  input  wire logic      clear_key_ack_i,
  output reg_data_t      key_data_o,
  output logic           key_valid_o,
  output logic           clear_key_o,
  // Response towards the decode stage
  output logic           resp_waiting_o,
  output reg_data_t      resp_word_o
);

  llki_state_e state;
  logic [7:0]  msg_id;
  logic [7:0]  status;
  logic [15:0] msg_len;
  logic        key_fwd;

  // A key word is passed on only when the core can take it
  assign key_fwd = (state == LOAD_KEY_WORDS) && sr_write_i && key_ready_i && !key_complete_i;

  // --------------------
  // Protocol FSM
  // --------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state          <= IDLE;
      msg_id         <= '0;
      status         <= '0;
      msg_len        <= '0;
      key_valid_o    <= 1'b0;
      clear_key_o    <= 1'b0;
      resp_waiting_o <= 1'b0;
    end else begin
      // Pulse outputs default low
      key_valid_o    <= 1'b0;
      clear_key_o    <= 1'b0;
      // Response flag drops as soon as the host reads the word
      resp_waiting_o <= (state == RESPONSE) && !sr_read_i;

      case (state)
        IDLE: begin
          // Capture header fields, upper word bits are ignored
          if (sr_write_i) begin
            msg_id  <= wdata_i[7:0];
            status  <= wdata_i[15:8];
            msg_len <= wdata_i[31:16];
            state   <= MSG_CHECK;
          end
        end

        MSG_CHECK: begin
          state <= RESPONSE;
          case (msg_id)
            MID_LOAD_KEY_REQ: begin
              // Header counts in msg_len, so at least one key word is needed
              if (msg_len <= 16'd1) begin
                msg_id <= MID_ERROR_RESP;
                status <= ST_BAD_MSG_LEN;
              end else if (key_complete_i) begin
                msg_id <= MID_ERROR_RESP;
                status <= ST_KEY_OVERWRITE;
              end else begin
                state <= LOAD_KEY_WORDS;
              end
            end
            MID_CLEAR_KEY_REQ: begin
              if (msg_len != 16'd1) begin
                msg_id <= MID_ERROR_RESP;
                status <= ST_BAD_MSG_LEN;
              end else begin
                clear_key_o <= 1'b1;
                state       <= CLEAR_KEY;
              end
            end
            MID_KEY_STATUS_REQ: begin
              if (msg_len != 16'd1) begin
                msg_id <= MID_ERROR_RESP;
                status <= ST_BAD_MSG_LEN;
              end else begin
                msg_id <= MID_KEY_STATUS_RESP;
                status <= key_complete_i ? ST_KEY_PRESENT : ST_KEY_NOT_PRESENT;
              end
            end
            default: begin
              msg_id <= MID_ERROR_RESP;
              status <= ST_BAD_MSG_ID;
            end
          endcase
        end

        LOAD_KEY_WORDS: begin
          if (sr_write_i) begin
            if (!key_ready_i) begin
              // Word is dropped, host lost track of ready-for-key
              msg_id <= MID_ERROR_RESP;
              status <= ST_LOSS_OF_SYNC;
              state  <= RESPONSE;
            end else if (key_complete_i) begin
              // Too many words, wipe the partial key before answering
              msg_id      <= MID_ERROR_RESP;
              status      <= ST_BAD_KEY_LEN;
              clear_key_o <= 1'b1;
              state       <= CLEAR_KEY;
            end else begin
              key_valid_o <= 1'b1;
              if (msg_len == 16'd2) begin
                // Last key word of the request
                msg_id <= MID_LOAD_KEY_ACK;
                status <= ST_GOOD;
                state  <= WAIT_COMPLETE;
              end else begin
                msg_len <= msg_len - 16'd1;
              end
            end
          end
        end

        WAIT_COMPLETE: begin
          if (key_complete_i) begin
            state <= RESPONSE;
          end
        end

        CLEAR_KEY: begin
          // Hold the request until the core acknowledges
          if (clear_key_ack_i) begin
            if (msg_id != MID_ERROR_RESP) begin
              msg_id <= MID_CLEAR_KEY_ACK;
              status <= ST_GOOD;
            end
            state <= RESPONSE;
          end else begin
            clear_key_o <= 1'b1;
          end
        end

        RESPONSE: begin
          if (sr_read_i) begin
            state <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Payload registers
  // --------------------
  always_ff @(posedge clk) begin
    if (key_fwd) begin
      key_data_o <= wdata_i;
    end
    // Response layout matches the header, length is always 1
    if (state == RESPONSE) begin
      resp_word_o <= {32'h0, 16'd1, status, msg_id};
    end else begin
      resp_word_o <= '0;
    end
  end

endmodule

`default_nettype wire

//--- src/llki_pp_top.sv
// Top level of the LLKI protocol processor, connecting the register decode and message stages
`timescale 1ns/10ps
`default_nettype none

module llki_pp_top import llki_pkg::*; #(
  parameter reg_addr_t CTRLSTS_ADDR  = 32'h0000_0000,
  parameter reg_addr_t SENDRECV_ADDR = 32'h0000_0008
) (
  input  wire logic      clk,
  input  wire logic      rst,
  // Host register port
  input  wire logic      reg_we_i,
  input  wire logic      reg_re_i,
  input  wire reg_addr_t reg_addr_i,
  input  wire reg_data_t reg_wdata_i,
  output reg_data_t      reg_rdata_o,
  output logic           reg_err_o,
  output logic           reg_ack_o,
  // Key discrete port
  output reg_data_t      key_data_o,
  output logic           key_valid_o,
  input  wire logic      key_ready_i,
  input  wire logic      key_complete_i,
  output logic           clear_key_o,
  input  wire logic      clear_key_ack_i
);

  // Stage to stage wires
  logic      sr_write;
  logic      sr_read;
  logic      resp_waiting;
  reg_data_t resp_word;

  // --------------------
  // Register decode stage
  // --------------------
  llki_reg_decode #(
    .CTRLSTS_ADDR  (CTRLSTS_ADDR),
    .SENDRECV_ADDR (SENDRECV_ADDR)
  ) u_reg_decode (
    .clk            (clk),
    .rst            (rst),
    .reg_we_i       (reg_we_i),
    .reg_re_i       (reg_re_i),
    .reg_addr_i     (reg_addr_i),
    .reg_rdata_o    (reg_rdata_o),
    .reg_err_o      (reg_err_o),
    .reg_ack_o      (reg_ack_o),
    .key_ready_i    (key_ready_i),
    .resp_waiting_i (resp_waiting),
    .resp_word_i    (resp_word),
    .sr_write_o     (sr_write),
    .sr_read_o      (sr_read)
  );

  // --------------------
  // Message stage
  // --------------------
  llki_msg_fsm u_msg_fsm (
    .clk             (clk),
    .rst             (rst),
    .sr_write_i      (sr_write),
    .sr_read_i       (sr_read),
    .wdata_i         (reg_wdata_i),
    .key_ready_i     (key_ready_i),
    .key_complete_i  (key_complete_i),
    .clear_key_ack_i (clear_key_ack_i),
    .key_data_o      (key_data_o),
    .key_valid_o     (key_valid_o),
    .clear_key_o     (clear_key_o),
    .resp_waiting_o  (resp_waiting),
    .resp_word_o     (resp_word)
  );

endmodule

`default_nettype wire

//--- sim/llki_clk_gen.sv
// Testbench clock and power-on reset source, instantiated once by the testbench top
`timescale 1ns/10ps
`default_nettype none

module llki_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_o
);

  // Free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held over a fixed count of rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/tb_llki_pp.sv
// Testbench for the LLKI protocol processor with a key port model and reference responses
`timescale 1ns/10ps
`default_nettype none

module tb_llki_pp import llki_pkg::*; ();

  localparam int        KEY_WORDS  = 2;
  localparam int        CLK_PERIOD = 40;
  localparam int        MAX_CYCLES = 4000;
  localparam int        POLL_LIMIT = 100;
  localparam reg_addr_t CTRLSTS    = 32'h0000_0000;
  localparam reg_addr_t SENDRECV   = 32'h0000_0008;
  localparam reg_addr_t UNMAPPED   = 32'h0000_0010;

  logic      clk;
  logic      rst;
  logic      reg_we;
  logic      reg_re;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      reg_err;
  logic      reg_ack;
  reg_data_t key_data;
  logic      key_valid;
  logic      key_ready;
  logic      key_complete;
  logic      clear_key;
  logic      clear_key_ack;

  // Bookkeeping
  integer    seed = 48;
  int        errors = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        cycles = 0;
  string     test_name;
  int        test_start_errors;
  logic      key_present;
  logic      clear_seen;
  reg_data_t exp_keys[$];

  llki_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(16)) u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  llki_pp_top #(.CTRLSTS_ADDR(CTRLSTS), .SENDRECV_ADDR(SENDRECV)) dut (
    .clk             (clk),
    .rst             (rst),
    .reg_we_i        (reg_we),
    .reg_re_i        (reg_re),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_rdata_o     (reg_rdata),
    .reg_err_o       (reg_err),
    .reg_ack_o       (reg_ack),
    .key_data_o      (key_data),
    .key_valid_o     (key_valid),
    .key_ready_i     (key_ready),
    .key_complete_i  (key_complete),
    .clear_key_o     (clear_key),
    .clear_key_ack_i (clear_key_ack)
  );

  // --------------------
  // Key port model
  // --------------------
  int   key_count;
  logic clear_ack_q;

  assign key_complete  = (key_count >= KEY_WORDS);
  // Core takes words unless it is busy wiping, so surplus words show up as bad length
  assign key_ready     = !clear_key && !clear_ack_q;
  assign clear_key_ack = clear_ack_q;

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      key_count   <= 0;
      clear_ack_q <= 1'b0;
    end else begin
      // Acknowledge one cycle after the request, then forget the key
      clear_ack_q <= clear_key;
      if (clear_ack_q) begin
        key_count <= 0;
      end else if (key_valid) begin
        key_count <= key_count + 1;
      end
    end
  end

  // Key word monitor, compares each forwarded word in order
  always @(negedge clk) begin
    if (clear_key) clear_seen = 1'b1;
    if (key_valid) begin
      assert (exp_keys.size() > 0) else begin
        $display("Error at %0d ns: a key word was forwarded that was not expected", $time);
        errors++;
      end
      if (exp_keys.size() > 0) check_word("key_data_o", key_data, exp_keys.pop_front());
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic reg_data_t expected_response(input reg_data_t header, input logic present,
                                                  input int words);
    logic [7:0]  id;
    logic [7:0]  st;
    logic [15:0] len;
    int          stored;
    len    = header[31:16];
    stored = 0;
    id     = MID_ERROR_RESP;
    st     = ST_BAD_MSG_LEN;
    case (header[7:0])
      MID_LOAD_KEY_REQ: begin
        if (len <= 16'd1) begin
          st = ST_BAD_MSG_LEN;
        end else if (present) begin
          st = ST_KEY_OVERWRITE;
        end else begin
          // Walk the words as the core sees them, ready is always high here
          for (int i = 0; i < words; i++) begin
            if (stored >= KEY_WORDS) begin
              st = ST_BAD_KEY_LEN;
              break;
            end
            stored++;
            if (len == 16'd2) begin
              id = MID_LOAD_KEY_ACK;
              st = ST_GOOD;
              break;
            end
            len = len - 16'd1;
          end
        end
      end
      MID_CLEAR_KEY_REQ: begin
        if (len == 16'd1) begin
          id = MID_CLEAR_KEY_ACK;
          st = ST_GOOD;
        end
      end
      MID_KEY_STATUS_REQ: begin
        if (len == 16'd1) begin
          id = MID_KEY_STATUS_RESP;
          st = present ? ST_KEY_PRESENT : ST_KEY_NOT_PRESENT;
        end
      end
      default: st = ST_BAD_MSG_ID;
    endcase
    return {32'h0, 16'd1, st, id};
  endfunction

  // Upper word bits carry junk, the DUT must ignore them
  function automatic reg_data_t make_header(input logic [7:0] id, input logic [15:0] len);
    return {32'hDEAD_BEEF, len, 8'h00, id};
  endfunction

  // --------------------
  // Checks
  // --------------------
  task automatic check_word(input string what, input reg_data_t got, input reg_data_t exp);
    assert (got === exp) else begin
      $display("Mismatch at %0d ns: %s expected %h, got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Mismatch at %0d ns: %s expected %b, got %b", $time, what, exp, got);
      errors++;
    end
  endtask

  // --------------------
  // Host bus tasks
  // --------------------
  task automatic reg_write(input reg_addr_t addr, input reg_data_t data, output logic err);
    int waited;
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
    waited = 0;
    while (!reg_ack && waited < POLL_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (reg_ack) else begin
      $display("Error at %0d ns: write to %h was never acknowledged", $time, addr);
      errors++;
    end
    err = reg_err;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data, output logic err);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    // Read answer is combinational, sample mid-cycle
    #(CLK_PERIOD / 4);
    assert (reg_ack) else begin
      $display("Error at %0d ns: read of %h was not acknowledged", $time, addr);
      errors++;
    end
    data = reg_rdata;
    err  = reg_err;
    @(negedge clk);
    reg_re = 1'b0;
  endtask

  task automatic poll_ctrlsts(input int bit_pos, input string what);
    reg_data_t sts;
    logic      err;
    int        polls;
    sts   = '0;
    polls = 0;
    while (!sts[bit_pos] && polls < POLL_LIMIT) begin
      reg_read(CTRLSTS, sts, err);
      polls++;
    end
    assert (sts[bit_pos]) else begin
      $display("Error at %0d ns: %s never came up in control/status", $time, what);
      errors++;
    end
  endtask

  task automatic send_key_words(input int words);
    reg_data_t word;
    logic      err;
    for (int i = 0; i < words; i++) begin
      word = {$random(seed), $random(seed)};
      // Empty core stores KEY_WORDS words at most
      if (i < KEY_WORDS) exp_keys.push_back(word);
      poll_ctrlsts(CTRLSTS_READY_FOR_KEY, "ready for key");
      reg_write(SENDRECV, word, err);
      check_flag("key word write error", err, 1'b0);
    end
  endtask

  // One request, its key words and the response read back
  task automatic run_request(input string name, input reg_data_t header, input int words);
    reg_data_t exp;
    reg_data_t got;
    logic      err;
    exp = expected_response(header, key_present, words);
    exp_keys.delete();
    clear_seen = 1'b0;
    reg_write(SENDRECV, header, err);
    check_flag("header write error", err, 1'b0);
    send_key_words(words);
    poll_ctrlsts(CTRLSTS_RESP_WAITING, "response waiting");
    reg_read(SENDRECV, got, err);
    check_flag("response read error", err, 1'b0);
    check_word({name, " response"}, got, exp);
    assert (exp_keys.size() == 0) else begin
      $display("Error at %0d ns: %0d key words were never forwarded", $time, exp_keys.size());
      errors++;
    end
    // Track the key that the port model now holds
    if (exp[7:0] == MID_LOAD_KEY_ACK) begin
      key_present = 1'b1;
    end else if (exp[7:0] == MID_CLEAR_KEY_ACK || exp[15:8] == ST_BAD_KEY_LEN) begin
      key_present = 1'b0;
    end
  endtask

  task automatic check_register_map;
    reg_data_t data;
    reg_data_t header;
    logic      err;
    reg_read(UNMAPPED, data, err);
    check_flag("unmapped read error", err, 1'b1);
    reg_write(UNMAPPED, 64'h1234_5678, err);
    check_flag("unmapped write error", err, 1'b1);
    reg_read(CTRLSTS, data, err);
    check_flag("control/status read error", err, 1'b0);
    reg_read(SENDRECV, data, err);
    check_flag("send/receive read error", err, 1'b0);
    // Response flag rises with a pending response and drops once it is read
    header = make_header(MID_KEY_STATUS_REQ, 16'd1);
    reg_write(SENDRECV, header, err);
    poll_ctrlsts(CTRLSTS_RESP_WAITING, "response waiting");
    reg_read(CTRLSTS, data, err);
    check_flag("response waiting before read", data[CTRLSTS_RESP_WAITING], 1'b1);
    reg_read(SENDRECV, data, err);
    check_word("status response", data, expected_response(header, key_present, 0));
    reg_read(CTRLSTS, data, err);
    check_flag("response waiting after read", data[CTRLSTS_RESP_WAITING], 1'b0);
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic finish_test;
    tests_run++;
    if (errors == test_start_errors) begin
      $display("Test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, test_name,
               errors - test_start_errors);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    reg_we      = 1'b0;
    reg_re      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    key_present = 1'b0;
    clear_seen  = 1'b0;
    @(negedge rst);

    start_test("status with no key");
    run_request("status", make_header(MID_KEY_STATUS_REQ, 16'd1), 0);
    finish_test();

    start_test("load two key words");
    run_request("load", make_header(MID_LOAD_KEY_REQ, 16'd3), 2);
    run_request("status", make_header(MID_KEY_STATUS_REQ, 16'd1), 0);
    finish_test();

    start_test("overwrite then clear");
    run_request("load over key", make_header(MID_LOAD_KEY_REQ, 16'd3), 0);
    run_request("clear", make_header(MID_CLEAR_KEY_REQ, 16'd1), 0);
    run_request("status", make_header(MID_KEY_STATUS_REQ, 16'd1), 0);
    finish_test();

    start_test("bad ID and lengths");
    run_request("unknown ID", make_header(8'h33, 16'd1), 0);
    run_request("clear length 2", make_header(MID_CLEAR_KEY_REQ, 16'd2), 0);
    run_request("load length 1", make_header(MID_LOAD_KEY_REQ, 16'd1), 0);
    finish_test();

    start_test("register map");
    check_register_map();
    finish_test();

    start_test("too many key words");
    run_request("load length 4", make_header(MID_LOAD_KEY_REQ, 16'd4), 3);
    check_flag("clear_key_o seen", clear_seen, 1'b1);
    run_request("status", make_header(MID_KEY_STATUS_REQ, 16'd1), 0);
    finish_test();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- llki_pp.f
src/llki_pkg.sv
src/llki_reg_decode.sv
src/llki_msg_fsm.sv
src/llki_pp_top.sv
sim/llki_clk_gen.sv
sim/tb_llki_pp.sv

//--- run_sim.sh
#!/bin/sh
# Build the LLKI protocol processor testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
  -f llki_pp.f --top-module tb_llki_pp -o tb_llki_pp_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_llki_pp_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "Simulation log has no pass line"
  exit 1
fi
exit 0
